// File: key_schedule.f
source/key_schedule_pkg.sv
source/expand_key_type_a_256.sv
source/expand_key_type_b_256.sv
source/key_expander.sv
source/round_key_store.sv
source/key_schedule_top.sv
tests/key_schedule_properties.sv
tests/key_schedule_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the key schedule testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module key_schedule_tb -f key_schedule.f -o sim_key_schedule

output=$(./obj_dir/sim_key_schedule 2>&1) || true
echo "$output"

if echo "$output" | grep -q "=== PASS ==="; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: source/expand_key_type_a_256.sv
/*
 * Type A key expansion step, rebuilds the upper four words
 */
`timescale 1ns/1ps
`default_nettype none

module expand_key_type_a_256
  import key_schedule_pkg::*;
(
  input  key256_t    in,
  input  word_t      rcon,
  output key256_t    out_1,
  output round_key_t out_2
);

  word_t mix;
  word_t v1;
  word_t v2;
  word_t v3;

  // Mixing word from the rotated last word plus the round constant
  assign mix = s4_mix(rotl8(in.k7)) ^ rcon;

  // Running XOR over the upper words
  assign v1 = in.k0 ^ in.k1;
  assign v2 = v1 ^ in.k2;
  assign v3 = v2 ^ in.k3;

  // Lower half passes through untouched
  assign out_1 = '{
    k0: in.k0 ^ mix,
    k1: v1 ^ mix,
    k2: v2 ^ mix,
    k3: v3 ^ mix,
    k4: in.k4,
    k5: in.k5,
    k6: in.k6,
    k7: in.k7
  };

  // New upper half is the round key
  assign out_2 = {out_1.k0, out_1.k1, out_1.k2, out_1.k3};

endmodule

`default_nettype wire

// File: source/expand_key_type_b_256.sv
/*
 * Type B key expansion step, rebuilds the lower four words
 */
`timescale 1ns/1ps
`default_nettype none

module expand_key_type_b_256
  import key_schedule_pkg::*;
(
  input  key256_t    in,
  output key256_t    out_1,
  output round_key_t out_2
);

  word_t mix;
  word_t v5;
  word_t v6;
  word_t v7;

  // No rotate and no constant on this step
  assign mix = s4_mix(in.k3);

  // Running XOR over the lower words
  assign v5 = in.k4 ^ in.k5;
  assign v6 = v5 ^ in.k6;
  assign v7 = v6 ^ in.k7;

  assign out_1 = '{
    k0: in.k0,
    k1: in.k1,
    k2: in.k2,
    k3: in.k3,
    k4: in.k4 ^ mix,
    k5: v5 ^ mix,
    k6: v6 ^ mix,
    k7: v7 ^ mix
  };

  // New lower half is the round key
  assign out_2 = {out_1.k4, out_1.k5, out_1.k6, out_1.k7};

endmodule

`default_nettype wire

// File: source/key_expander.sv
/*
 * Key schedule sequencer, loads the key and emits one round key per cycle
 * Alternates type A and type B steps and tracks the round constant
 */
`timescale 1ns/1ps
`default_nettype none

module key_expander
  import key_schedule_pkg::*;
#(
  parameter int NUM_ROUNDS = 15
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  key256_t    key,
  output logic       busy,
  output logic       rk_valid,
  output rk_index_t  rk_index,
  output round_key_t rk,
  output logic       done
);

  localparam rk_index_t LAST_INDEX = rk_index_t'(NUM_ROUNDS - 1);

  key256_t    state;
  word_t      rcon;
  rk_index_t  round_cnt;

  key256_t    a_out_1;
  round_key_t a_out_2;
  key256_t    b_out_1;
  round_key_t b_out_2;

  key256_t    state_next;
  word_t      rcon_next;
  round_key_t rk_next;
  logic       load;
  logic       emit;

  expand_key_type_a_256 i_expand_key_type_a_256 (
    .in    (state),
    .rcon  (rcon),
    .out_1 (a_out_1),
    .out_2 (a_out_2)
  );

  expand_key_type_b_256 i_expand_key_type_b_256 (
    .in    (state),
    .out_1 (b_out_1),
    .out_2 (b_out_2)
  );

  assign load = start && !busy;

  // Cycle after done only drops busy
  assign emit = busy && !done;

  // Pick the round key and the next state for the current index
  always_comb begin
    state_next = state;
    rcon_next  = rcon;
    if (round_cnt == '0) begin
      rk_next = {state.k0, state.k1, state.k2, state.k3};
    end else if (round_cnt == rk_index_t'(1)) begin
      rk_next = {state.k4, state.k5, state.k6, state.k7};
    end else if (!round_cnt[0]) begin
      rk_next    = a_out_2;
      state_next = a_out_1;
      rcon_next  = {rcon[30:0], 1'b0};
    end else begin
      rk_next    = b_out_2;
      state_next = b_out_1;
    end
  end

  // Sequencing and output strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      rk_valid  <= 1'b0;
      done      <= 1'b0;
      rk_index  <= '0;
      round_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy      <= 1'b1;
        round_cnt <= '0;
      end
    end else if (done) begin
      // Last key went out on the previous cycle
      busy     <= 1'b0;
      rk_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      rk_valid  <= 1'b1;
      rk_index  <= round_cnt;
      done      <= (round_cnt == LAST_INDEX);
      round_cnt <= round_cnt + rk_index_t'(1);
    end
  end

  // Key state, round constant and round key payload
  always_ff @(posedge clk) begin
    if (load) begin
      state <= key;
      rcon  <= word_t'(1);
    end else if (emit) begin
      state <= state_next;
      rcon  <= rcon_next;
      rk    <= rk_next;
    end
  end

endmodule

`default_nettype wire

// File: source/key_schedule_pkg.sv
/*
 * Word, expanded key state, round key and index types
 * S4 mixing and byte rotate helpers for the expansion steps
 */
`default_nettype none

package key_schedule_pkg;

  // Store depth limit, also sets the index width
  localparam int MAX_ROUNDS = 16;

  typedef logic [31:0] word_t;

  typedef logic [127:0] round_key_t;

  typedef logic [$clog2(MAX_ROUNDS)-1:0] rk_index_t;

  // Eight word key state, k0 is the most significant word
  typedef struct packed {
    word_t k0;
    word_t k1;
    word_t k2;
    word_t k3;
    word_t k4;
    word_t k5;
    word_t k6;
    word_t k7;
  } key256_t;

  // S4 spreads each bit over three positions of the word
  function automatic word_t s4_mix(input word_t x);
    word_t y;
    y = x ^ (x << 11) ^ (x << 22);
    return y;
  endfunction

  // Byte rotate, top byte wraps to the bottom
  function automatic word_t rotl8(input word_t x);
    word_t y;
    y = {x[23:0], x[31:24]};
    return y;
  endfunction

endpackage

`default_nettype wire

// File: source/key_schedule_top.sv
/*
 * Key schedule top level, expander feeding the round key store
 */
`timescale 1ns/1ps
`default_nettype none

module key_schedule_top
  import key_schedule_pkg::*;
#(
  parameter int NUM_ROUNDS = 15
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  key256_t    key,
  input  rk_index_t  rd_index,
  output logic       busy,
  output logic       rk_valid,
  output rk_index_t  rk_index,
  output round_key_t rk,
  output logic       done,
  output round_key_t rd_key,
  output logic       rd_hit
);

  logic start_accept;

  // Store only clears on a start the expander will take
  assign start_accept = start && !busy;

  key_expander #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) i_key_expander (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .key      (key),
    .busy     (busy),
    .rk_valid (rk_valid),
    .rk_index (rk_index),
    .rk       (rk),
    .done     (done)
  );

  round_key_store #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) i_round_key_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start_accept),
    .rk_valid (rk_valid),
    .rk_index (rk_index),
    .rk       (rk),
    .rd_index (rd_index),
    .rd_key   (rd_key),
    .rd_hit   (rd_hit)
  );

endmodule

`default_nettype wire

// File: source/round_key_store.sv
/*
 * Round key register array with per-entry valid bits and a combinational read
 */
`timescale 1ns/1ps
`default_nettype none

module round_key_store
  import key_schedule_pkg::*;
#(
  parameter int NUM_ROUNDS = 15
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       rk_valid,
  input  rk_index_t  rk_index,
  input  round_key_t rk,
  input  rk_index_t  rd_index,
  output round_key_t rd_key,
  output logic       rd_hit
);

  round_key_t            entries [NUM_ROUNDS];
  logic [NUM_ROUNDS-1:0] valid;
  logic                  wr_in_range;
  logic                  rd_in_range;
  logic                  wr_en;

  assign wr_in_range = int'(rk_index) < NUM_ROUNDS;
  assign rd_in_range = int'(rd_index) < NUM_ROUNDS;
  assign wr_en       = rk_valid && wr_in_range;

  // Start wipes every entry so stale keys never hit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= '0;
    end else if (start) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[rk_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[rk_index] <= rk;
    end
  end

  // Out of range reads return zero and miss
  always_comb begin
    rd_key = '0;
    rd_hit = 1'b0;
    if (rd_in_range) begin
      rd_key = entries[rd_index];
      rd_hit = valid[rd_index];
    end
  end

endmodule

`default_nettype wire

// File: tests/key_schedule_properties.sv
/*
 * Concurrent checks on the key expander sequencing, bound into key_expander
 */
`timescale 1ns/1ps
`default_nettype none

module key_schedule_properties
  import key_schedule_pkg::*;
#(
  parameter int NUM_ROUNDS = 15
) (
  input logic      clk,
  input logic      rst_n,
  input logic      busy,
  input logic      rk_valid,
  input rk_index_t rk_index,
  input logic      done
);

  localparam rk_index_t LAST_INDEX = rk_index_t'(NUM_ROUNDS - 1);

  // One failure count per property
  int valid_busy_errors = 0;
  int done_last_errors = 0;
  int index_step_errors = 0;
  int done_idle_errors = 0;
  int failures;

  assign failures = valid_busy_errors + done_last_errors + index_step_errors
                    + done_idle_errors;

  valid_implies_busy: assert property (
    @(posedge clk) disable iff (!rst_n) rk_valid |-> busy
  ) else begin
    valid_busy_errors++;
    $error("rk_valid high while busy is low");
  end

  // Done marks the last key of the schedule
  done_on_last_key: assert property (
    @(posedge clk) disable iff (!rst_n) done |-> (rk_valid && rk_index == LAST_INDEX)
  ) else begin
    done_last_errors++;
    $error("done without rk_valid on the last index");
  end

  index_steps_by_one: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rk_valid && $past(rk_valid)) |-> (rk_index == $past(rk_index) + rk_index_t'(1))
  ) else begin
    index_step_errors++;
    $error("rk_index did not advance by one between keys");
  end

  done_then_idle: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !busy
  ) else begin
    done_idle_errors++;
    $error("busy still high after done");
  end

endmodule

bind key_expander key_schedule_properties #(
  .NUM_ROUNDS (NUM_ROUNDS)
) i_key_schedule_properties (
  .clk      (clk),
  .rst_n    (rst_n),
  .busy     (busy),
  .rk_valid (rk_valid),
  .rk_index (rk_index),
  .done     (done)
);

`default_nettype wire

// File: tests/key_schedule_tb.sv
/*
 * Key schedule testbench with LFSR keys and a reference schedule model
 * Checks the round key stream, the store readback and ignored restarts
 */
`timescale 1ns/1ps
`default_nettype none

module key_schedule_tb
  import key_schedule_pkg::*;
();

  localparam int NUM_ROUNDS = 15;
  localparam int NUM_KEYS = 20;
  localparam int TIMEOUT_CYCLES = NUM_KEYS * 40;

  logic       clk;
  logic       rst_n;
  logic       start;
  key256_t    key;
  rk_index_t  rd_index;
  logic       busy;
  logic       rk_valid;
  rk_index_t  rk_index;
  round_key_t rk;
  logic       done;
  round_key_t rd_key;
  logic       rd_hit;

  logic [31:0] lfsr = 32'h862a788a;
  int          cycle_count = 0;
  round_key_t  expected [NUM_ROUNDS];

  key_schedule_top #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) i_key_schedule_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .key      (key),
    .rd_index (rd_index),
    .busy     (busy),
    .rk_valid (rk_valid),
    .rk_index (rk_index),
    .rk       (rk),
    .done     (done),
    .rd_key   (rd_key),
    .rd_hit   (rd_hit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "Simulation timed out");
    end
  end

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  function automatic word_t random_word();
    word_t w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return w;
  endfunction

  // Some keys get a zero k3 or k7
  // Last key makes the round 2 mix only rcon and the round 3 mix zero
  function automatic key256_t make_key(input int n);
    key256_t k;
    k.k0 = random_word();
    k.k1 = random_word();
    k.k2 = random_word();
    k.k3 = random_word();
    k.k4 = random_word();
    k.k5 = random_word();
    k.k6 = random_word();
    k.k7 = random_word();
    if (n % 5 == 2) begin
      k.k3 = '0;
    end
    if (n % 5 == 4 || n == NUM_KEYS - 1) begin
      k.k7 = '0;
    end
    if (n == NUM_KEYS - 1) begin
      k.k3 = k.k0 ^ k.k1 ^ k.k2 ^ 32'd1;
    end
    return k;
  endfunction

  function automatic word_t ref_s4(input word_t x);
    return x ^ {x[20:0], 11'd0} ^ {x[9:0], 22'd0};
  endfunction

  // Reference schedule on a plain word array
  task automatic build_expected(input key256_t k);
    logic [255:0] flat;
    word_t        w [8];
    word_t        mix;
    word_t        acc;
    word_t        rc;
    flat = k;
    for (int j = 0; j < 8; j++) begin
      w[j] = flat[255 - 32 * j -: 32];
    end
    rc = 32'd1;
    for (int i = 0; i < NUM_ROUNDS; i++) begin
      acc = '0;
      if (i >= 2 && i % 2 == 0) begin
        mix = ref_s4((w[7] << 8) | (w[7] >> 24)) ^ rc;
        for (int j = 0; j < 4; j++) begin
          acc = acc ^ w[j];
          w[j] = acc ^ mix;
        end
        rc = rc << 1;
      end else if (i >= 2) begin
        mix = ref_s4(w[3]);
        for (int j = 4; j < 8; j++) begin
          acc = acc ^ w[j];
          w[j] = acc ^ mix;
        end
      end
      if (i % 2 == 0) begin
        expected[i] = {w[0], w[1], w[2], w[3]};
      end else begin
        expected[i] = {w[4], w[5], w[6], w[7]};
      end
    end
  endtask

  task automatic check_round_key(input string name, input round_key_t exp_val,
                                 input round_key_t act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      $display("=== FAIL ===");
      $fatal(1, "Round key mismatch");
    end
  endtask

  task automatic check_index(input string name, input rk_index_t exp_val,
                             input rk_index_t act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s expected %0d actual %0d", name, exp_val, act_val);
      $display("=== FAIL ===");
      $fatal(1, "Round key index mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("ERR %s expected %b actual %b", name, exp_val, act_val);
      $display("=== FAIL ===");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic check_reset();
    for (int j = 0; j < MAX_ROUNDS; j++) begin
      @(negedge clk);
      rd_index = rk_index_t'(j);
      #1;
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset rk_valid", 1'b0, rk_valid);
      check_flag("reset done", 1'b0, done);
      check_index("reset rk_index", '0, rk_index);
      check_flag($sformatf("reset rd_hit %0d", j), 1'b0, rd_hit);
    end
  endtask

  // One schedule: start, stream with reads, then full readback
  task automatic run_key(input key256_t k, input int n);
    key256_t decoy;
    int      target;
    logic    hit_exp;
    build_expected(k);
    decoy = make_key(n + 1);
    @(negedge clk);
    start = 1'b1;
    key = k;
    #1;
    check_flag($sformatf("key %0d idle before start", n), 1'b0, busy);
    @(negedge clk);
    start = 1'b0;
    key = decoy;
    rd_index = rk_index_t'(n % MAX_ROUNDS);
    #1;
    check_flag($sformatf("key %0d accepted", n), 1'b1, busy);
    check_flag($sformatf("key %0d no key yet", n), 1'b0, rk_valid);
    check_flag($sformatf("key %0d store cleared", n), 1'b0, rd_hit);
    for (int i = 0; i < NUM_ROUNDS; i++) begin
      @(negedge clk);
      // Restart attempts while busy, mid stream or on the done cycle
      start = (n % 4 == 1 && i == 5) || (n % 4 == 3 && i == NUM_ROUNDS - 1);
      hit_exp = (n % 2 == 1 && i > 0);
      target = hit_exp ? i - 1 : i;
      rd_index = rk_index_t'(target);
      #1;
      check_flag($sformatf("key %0d stream %0d rk_valid", n, i), 1'b1, rk_valid);
      check_flag($sformatf("key %0d stream %0d busy", n, i), 1'b1, busy);
      check_index($sformatf("key %0d stream %0d rk_index", n, i), rk_index_t'(i), rk_index);
      check_round_key($sformatf("key %0d stream %0d rk", n, i), expected[i], rk);
      check_flag($sformatf("key %0d stream %0d done", n, i), i == NUM_ROUNDS - 1, done);
      check_flag($sformatf("key %0d write edge %0d rd_hit", n, target), hit_exp, rd_hit);
      if (hit_exp) begin
        check_round_key($sformatf("key %0d early read %0d", n, target), expected[target],
                        rd_key);
      end
    end
    @(negedge clk);
    start = 1'b0;
    #1;
    check_flag($sformatf("key %0d busy after done", n), 1'b0, busy);
    check_flag($sformatf("key %0d rk_valid after done", n), 1'b0, rk_valid);
    check_flag($sformatf("key %0d done after done", n), 1'b0, done);
    for (int j = 0; j < MAX_ROUNDS; j++) begin
      @(negedge clk);
      rd_index = rk_index_t'(j);
      #1;
      check_flag($sformatf("key %0d readback %0d rd_hit", n, j), j < NUM_ROUNDS, rd_hit);
      if (j < NUM_ROUNDS) begin
        check_round_key($sformatf("key %0d readback %0d", n, j), expected[j], rd_key);
      end else begin
        check_round_key($sformatf("key %0d readback %0d zero", n, j), '0, rd_key);
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    key = '0;
    rd_index = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_reset();
    for (int n = 0; n < NUM_KEYS; n++) begin
      run_key(make_key(n), n);
    end
    if (i_key_schedule_top.i_key_expander.i_key_schedule_properties.failures == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Expander sequencing assertions failed");
      $display("=== FAIL ===");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

`default_nettype wire
